// File: flist.f
verilog/motion_pkg.sv
verilog/spi_word_port.sv
verilog/command_decoder.sv
verilog/move_queue.sv
verilog/step_generator.sv
verilog/hbridge_phase.sv
verilog/quad_encoder.sv
verilog/motion_top.sv
dv/motion_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the motion controller testbench with Verilator.
# Exits non-zero on a build error, a simulator error or a failing test.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module motion_tb -f flist.f \
  -Mdir obj_dir -o Vmotion_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vmotion_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: dv/motion_tb.sv
module motion_tb;
  import motion_pkg::*;

  // Test kinds in the stimulus table
  localparam int K_DISABLED = 0;
  localparam int K_VERSION  = 1;
  localparam int K_ENCODER  = 2;
  localparam int K_FAULT    = 3;
  localparam int K_MOVES    = 4;
  localparam int K_LED      = 5;
  localparam int NUM_TESTS  = 7;
  localparam int MOVE_DIV   = 4;
  // Upper bound on CLK cycles for one SPI word
  localparam int WORD_CYCLES = 600;

  typedef struct packed {
    logic [3:0]  kind;
    logic [15:0] count_a;
    logic [15:0] count_b;
    logic [63:0] expect_val;
  } test_entry_t;

  logic CLK;
  logic reset;
  logic sck;
  logic cs;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic enc_fault;
  logic led;

  test_entry_t tests [NUM_TESTS];
  move_t       moves [8];
  int move_pos;
  int enc_pos;
  int errors;
  int watchdog_cycles;
  // Phase monitor state
  int   stride;
  int   fwd_steps;
  int   bwd_steps;
  int   bad_moves;
  int   active_cycles;
  int   led_toggles;
  int   last_idx;
  logic have_idx;
  logic led_seen;
  int   run_dir[$];
  int   run_len[$];

  motion_top dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Coil pattern {a1,a2,b1,b2} back to the half-step position or -1
  function automatic int decode_phase(input logic [3:0] p);
    case (p)
      4'b1000: return 0;
      4'b1010: return 1;
      4'b0010: return 2;
      4'b0110: return 3;
      4'b0100: return 4;
      4'b0101: return 5;
      4'b0001: return 6;
      4'b1001: return 7;
      default: return -1;
    endcase
  endfunction

  // A leads B going forward
  function automatic logic [1:0] quad_ab(input int pos);
    case (pos)
      0:       return 2'b00;
      1:       return 2'b10;
      2:       return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  // DDA rule where tick k uses rate + k * rate_delta
  function automatic int dda_model_steps(input move_t mv);
    logic signed [63:0] acc;
    logic signed [63:0] rate_k;
    longint k;
    int n;
    acc = '0;
    n = 0;
    for (k = 0; k < longint'(mv.duration); k++) begin
      rate_k = $signed(mv.rate) + k * $signed(mv.rate_delta);
      acc = acc + rate_k;
      if (acc > 0) begin
        n++;
        acc = acc - (64'sd1 <<< 40);
      end
    end
    return n;
  endfunction

  // Rate between 2**38 and 2**39 with a small signed slope
  function automatic move_t random_move(input int dur, input logic dir);
    move_t mv;
    logic [31:0] r;
    mv.dir = dir;
    mv.duration = 64'(dur);
    mv.rate = (64'sd1 <<< 38) + $signed({26'd0, $urandom(), 6'd0});
    r = $urandom();
    mv.rate_delta = $signed({{36{r[27]}}, r[27:0]});
    return mv;
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      K_DISABLED: return "disabled_motor";
      K_VERSION:  return "version_read";
      K_ENCODER:  return "encoder_count";
      K_FAULT:    return "encoder_fault";
      K_MOVES:    return "queued_moves";
      default:    return "led_activity";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Phase decoder and led edge counter sampled on the falling edge
  always @(negedge CLK) begin
    logic [3:0] p;
    int idx;
    int diff;
    p = {phase_a1, phase_a2, phase_b1, phase_b2};
    if (led !== led_seen) begin
      led_toggles++;
    end
    led_seen = led;
    if (p == 4'b0000) begin
      have_idx = 1'b0;
    end else begin
      active_cycles++;
      idx = decode_phase(p);
      if (idx < 0) begin
        bad_moves++;
      end else begin
        if (have_idx && idx != last_idx) begin
          diff = (idx - last_idx + 8) % 8;
          if (diff == stride || diff == 8 - stride) begin
            if (diff == stride) begin
              fwd_steps++;
            end else begin
              bwd_steps++;
            end
            // Runs of same-direction steps in order
            if (run_dir.size() == 0 || run_dir[run_dir.size()-1] != int'(diff == stride)) begin
              run_dir.push_back(int'(diff == stride));
              run_len.push_back(1);
            end else begin
              run_len[run_len.size()-1] = run_len[run_len.size()-1] + 1;
            end
          end else begin
            bad_moves++;
          end
        end
        last_idx = idx;
        have_idx = 1'b1;
      end
    end
  end

  // One 64-bit SPI word MSB first with SCK at CLK/8
  task automatic xfer_word(input logic [63:0] tx, output logic [63:0] rx);
    logic led_before;
    int i;
    int waited;
    @(negedge CLK);
    led_before = led;
    @(posedge CLK);
    cs <= 1'b0;
    repeat (8) @(posedge CLK);
    for (i = 63; i >= 0; i--) begin
      sck  <= 1'b0;
      copi <= tx[i];
      repeat (3) @(posedge CLK);
      // Port shifts cipo 3 cycles after SCK falls
      @(negedge CLK);
      rx[i] = cipo;
      @(posedge CLK);
      sck <= 1'b1;
      repeat (4) @(posedge CLK);
    end
    sck <= 1'b0;
    repeat (4) @(posedge CLK);
    cs <= 1'b1;
    waited = 0;
    @(negedge CLK);
    while (led == led_before && waited < 32) begin
      @(negedge CLK);
      waited++;
    end
    if (led == led_before) begin
      $display("SPI word %h was not acknowledged on led at %0t", tx, $time);
      errors++;
    end
    repeat (6) @(posedge CLK);
  endtask

  task automatic send_header(input logic [7:0] cmd, input logic [55:0] arg);
    logic [63:0] rx;
    xfer_word({cmd, arg}, rx);
  endtask

  task automatic send_move(input move_t mv);
    logic [63:0] rx;
    send_header(CMD_MOVE, {55'd0, mv.dir});
    xfer_word(mv.duration, rx);
    xfer_word(mv.rate, rx);
    xfer_word(mv.rate_delta, rx);
  endtask

  // Queue empty and generator idle for a few cycles in a row
  task automatic wait_idle(input int limit);
    int waited;
    int idle_run;
    waited = 0;
    idle_run = 0;
    while (idle_run < 4 && waited < limit) begin
      @(negedge CLK);
      waited++;
      if (!dut0.push_req && !dut0.push_ack && !dut0.pop_req && !dut0.pop_ack
          && !dut0.u_step.busy) begin
        idle_run++;
      end else begin
        idle_run = 0;
      end
    end
    if (idle_run < 4) begin
      $display("Moves were still running after %0d cycles at %0t", waited, $time);
      errors++;
    end
    @(posedge CLK);
  endtask

  task automatic step_encoder(input int delta);
    enc_pos = (enc_pos + delta + 4) % 4;
    @(posedge CLK);
    {enc_a, enc_b} <= quad_ab(enc_pos);
    repeat (8) @(posedge CLK);
  endtask

  // Motor left disabled as it comes out of reset
  task automatic move_while_disabled(input test_entry_t t);
    move_t mv;
    @(posedge CLK);
    active_cycles = 0;
    mv = moves[move_pos];
    move_pos++;
    send_move(mv);
    wait_idle(int'(mv.duration) * int'(DIVISOR_RESET) + 1000);
    check_value("phase_active_cycles", 64'(active_cycles), t.expect_val);
  endtask

  task automatic read_version(input test_entry_t t);
    logic [63:0] rx;
    send_header(CMD_VERSION, 56'd0);
    xfer_word(64'd0, rx);
    check_value("cipo_word", rx, t.expect_val);
  endtask

  task automatic count_encoder_steps(input test_entry_t t);
    logic [63:0] rx;
    int j;
    for (j = 0; j < int'(t.count_a); j++) begin
      step_encoder(1);
    end
    for (j = 0; j < int'(t.count_b); j++) begin
      step_encoder(-1);
    end
    // Count captured at the end of this word is returned on the next
    send_header(8'd0, 56'd0);
    xfer_word(64'd0, rx);
    check_value("enc_count", rx, t.expect_val);
  endtask

  task automatic force_encoder_fault(input test_entry_t t);
    int waited;
    enc_pos = (enc_pos + 2) % 4;
    @(posedge CLK);
    {enc_a, enc_b} <= quad_ab(enc_pos);
    waited = 0;
    @(negedge CLK);
    while (!enc_fault && waited < 16) begin
      @(negedge CLK);
      waited++;
    end
    check_value("enc_fault", 64'(enc_fault), t.expect_val);
  endtask

  task automatic execute_moves(input test_entry_t t);
    move_t mv;
    int j;
    int d;
    int steps;
    int budget;
    int exp_fwd;
    int exp_bwd;
    int exp_dir[$];
    int exp_len[$];
    send_header(CMD_ENABLE, 56'd1);
    send_header(CMD_DIVISOR, 56'(MOVE_DIV));
    send_header(CMD_MICROSTEPS, 56'(t.count_b));
    @(posedge CLK);
    stride = int'(t.expect_val);
    fwd_steps = 0;
    bwd_steps = 0;
    bad_moves = 0;
    run_dir.delete();
    run_len.delete();
    exp_fwd = 0;
    exp_bwd = 0;
    budget = 1000;
    for (j = 0; j < int'(t.count_a); j++) begin
      mv = moves[move_pos];
      move_pos++;
      steps = dda_model_steps(mv);
      d = mv.dir ? 1 : 0;
      if (d == 1) begin
        exp_fwd += steps;
      end else begin
        exp_bwd += steps;
      end
      if (steps > 0 && exp_dir.size() > 0 && exp_dir[exp_dir.size()-1] == d) begin
        exp_len[exp_len.size()-1] = exp_len[exp_len.size()-1] + steps;
      end else if (steps > 0) begin
        exp_dir.push_back(d);
        exp_len.push_back(steps);
      end
      budget += int'(mv.duration) * MOVE_DIV;
      send_move(mv);
    end
    wait_idle(budget);
    check_value("fwd_steps", 64'(fwd_steps), 64'(exp_fwd));
    check_value("bwd_steps", 64'(bwd_steps), 64'(exp_bwd));
    check_value("bad_phase_changes", 64'(bad_moves), 64'd0);
    check_value("step_runs", 64'(run_len.size()), 64'(exp_len.size()));
    if (run_len.size() == exp_len.size()) begin
      for (j = 0; j < exp_len.size(); j++) begin
        check_value($sformatf("run_dir[%0d]", j), 64'(run_dir[j]), 64'(exp_dir[j]));
        check_value($sformatf("run_len[%0d]", j), 64'(run_len[j]), 64'(exp_len[j]));
      end
    end
  endtask

  task automatic count_led_toggles(input test_entry_t t);
    int start;
    int j;
    @(posedge CLK);
    start = led_toggles;
    for (j = 0; j < int'(t.count_a); j++) begin
      send_header(8'd0, 56'd0);
    end
    @(posedge CLK);
    check_value("led_toggles", 64'(led_toggles - start), t.expect_val);
  endtask

  // Moves, table and watchdog limit from the seeded generator
  task automatic build_table();
    int i;
    int n;
    int m;
    int total;
    moves[0] = random_move(40, 1'b1);
    total = 40 * int'(DIVISOR_RESET);
    for (i = 1; i < 8; i++) begin
      moves[i] = random_move(600 + int'($urandom() % 200), i[0]);
      total += int'(moves[i].duration) * MOVE_DIV;
    end
    n = 5 + int'($urandom() % 20);
    m = int'($urandom() % n);
    tests[0] = '{K_DISABLED, 16'd1, 16'd0, 64'd0};
    tests[1] = '{K_VERSION, 16'd0, 16'd0,
                 {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH}};
    tests[2] = '{K_ENCODER, 16'(n), 16'(m), 64'(n - m)};
    tests[3] = '{K_FAULT, 16'd0, 16'd0, 64'd1};
    // Full step with stride 2
    tests[4] = '{K_MOVES, 16'd3, 16'd1, 64'd2};
    // Half step with stride 1 and four moves back to back
    tests[5] = '{K_MOVES, 16'd4, 16'd2, 64'd1};
    tests[6] = '{K_LED, 16'd3, 16'd0, 64'd3};
    watchdog_cycles = total + 60 * WORD_CYCLES + 20000;
  endtask

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int i;
    int errs_before;
    int passed;
    int failed;
    reset = 1'b1;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    errors = 0;
    passed = 0;
    failed = 0;
    move_pos = 0;
    enc_pos = 0;
    stride = 2;
    have_idx = 1'b0;
    led_seen = 1'b0;
    watchdog_cycles = 0;
    void'($urandom(32'hd436));
    build_table();
    repeat (5) @(posedge CLK);
    reset <= 1'b0;
    @(posedge CLK);
    for (i = 0; i < NUM_TESTS; i++) begin
      errs_before = errors;
      case (int'(tests[i].kind))
        K_DISABLED: move_while_disabled(tests[i]);
        K_VERSION:  read_version(tests[i]);
        K_ENCODER:  count_encoder_steps(tests[i]);
        K_FAULT:    force_encoder_fault(tests[i]);
        K_MOVES:    execute_moves(tests[i]);
        default:    count_led_toggles(tests[i]);
      endcase
      if (errors == errs_before) begin
        passed++;
      end else begin
        failed++;
      end
      $display("[test %0d] %s: %s", i, kind_name(int'(tests[i].kind)),
               (errors == errs_before) ? "PASS" : "FAIL");
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             NUM_TESTS, passed, failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/motion_top.sv
module motion_top (
  input  logic CLK,
  input  logic reset,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic enc_fault,
  output logic led
);
  import motion_pkg::*;

  spi_word_u          rx_word;
  spi_word_u          tx_word;
  logic               word_done;
  move_t              push_move;
  move_t              pop_move;
  logic               push_req;
  logic               push_ack;
  logic               pop_req;
  logic               pop_ack;
  logic               enable;
  logic [1:0]         microsteps;
  logic [7:0]         divisor;
  logic               step;
  logic               dir;
  logic signed [63:0] enc_count;

  spi_word_port u_spi (.CLK, .reset, .sck, .cs, .copi, .cipo, .tx_word, .rx_word, .word_done);

  command_decoder u_dec (.CLK, .reset, .rx_word, .word_done, .tx_word, .push_req, .push_ack,
                         .push_move, .enable, .microsteps, .divisor, .enc_count);

  move_queue u_queue (.CLK, .reset, .push_req, .push_ack, .push_move, .pop_req, .pop_ack,
                      .pop_move);

  step_generator u_step (.CLK, .reset, .pop_req, .pop_ack, .pop_move, .divisor, .step, .dir);

  hbridge_phase u_bridge (.CLK, .reset, .step, .dir, .enable, .microsteps, .phase_a1,
                          .phase_a2, .phase_b1, .phase_b2);

  quad_encoder u_enc (.CLK, .reset, .enc_a, .enc_b, .count(enc_count), .fault(enc_fault));

  // Activity light, one toggle per SPI word
  always_ff @(posedge CLK) begin
    if (reset) begin
      led <= 1'b0;
    end else if (word_done) begin
      led <= ~led;
    end
  end

endmodule

// File: verilog/quad_encoder.sv
module quad_encoder (
  input  logic               CLK,
  input  logic               reset,
  input  logic               enc_a,
  input  logic               enc_b,
  output logic signed [63:0] count,
  output logic               fault
);

  logic [1:0] a_s;
  logic [1:0] b_s;
  logic       prev_a;
  logic       prev_b;
  logic       moved;
  logic       both;
  logic       fwd;

  // Exactly one input changed
  assign moved = (a_s[1] ^ prev_a) ^ (b_s[1] ^ prev_b);
  // Both changed, an illegal transition
  assign both  = (a_s[1] ^ prev_a) & (b_s[1] ^ prev_b);
  // A leads B: 00 10 11 01
  assign fwd   = a_s[1] ^ prev_b;

  always_ff @(posedge CLK) begin
    if (reset) begin
      a_s    <= '0;
      b_s    <= '0;
      prev_a <= 1'b0;
      prev_b <= 1'b0;
      count  <= '0;
      fault  <= 1'b0;
    end else begin
      a_s    <= {a_s[0], enc_a};
      b_s    <= {b_s[0], enc_b};
      prev_a <= a_s[1];
      prev_b <= b_s[1];
      if (both) begin
        // Sticky until reset
        fault <= 1'b1;
      end else if (moved) begin
        count <= fwd ? count + 64'sd1 : count - 64'sd1;
      end
    end
  end

endmodule

// File: verilog/hbridge_phase.sv
module hbridge_phase (
  input  logic       CLK,
  input  logic       reset,
  input  logic       step,
  input  logic       dir,
  input  logic       enable,
  input  logic [1:0] microsteps,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2
);

  logic [2:0] phase_idx;
  logic [2:0] stride;
  logic [3:0] coils;

  // Half step walks every entry, full step every other one
  assign stride = (microsteps == 2'd2) ? 3'd1 : 3'd2;

  always_ff @(posedge CLK) begin
    if (reset) begin
      phase_idx <= '0;
    end else if (step && enable) begin
      // Wraps around the eight entry table
      phase_idx <= dir ? phase_idx + stride : phase_idx - stride;
    end
  end

  // {a1, a2, b1, b2}, A+ then AB, B+, and so on
  always_comb begin
    case (phase_idx)
      3'd0:    coils = 4'b1000;
      3'd1:    coils = 4'b1010;
      3'd2:    coils = 4'b0010;
      3'd3:    coils = 4'b0110;
      3'd4:    coils = 4'b0100;
      3'd5:    coils = 4'b0101;
      3'd6:    coils = 4'b0001;
      default: coils = 4'b1001;
    endcase
  end

  // Coils off when disabled
  assign {phase_a1, phase_a2, phase_b1, phase_b2} = enable ? coils : 4'b0000;

endmodule

// File: verilog/step_generator.sv
module step_generator (
  input  logic              CLK,
  input  logic              reset,
  input  logic              pop_req,
  output logic              pop_ack,
  input  motion_pkg::move_t pop_move,
  input  logic [7:0]        divisor,
  output logic              step,
  output logic              dir
);
  import motion_pkg::*;

  logic               busy;
  logic               load;
  logic               tick;
  logic [7:0]         div_cnt;
  logic [63:0]        remaining;
  logic signed [63:0] cur_rate;
  logic signed [63:0] rate_delta;
  logic signed [63:0] accum;
  logic signed [63:0] accum_next;

  assign load       = !busy && pop_req && !pop_ack;
  // Divisor of 0 or 1 gives a tick every cycle
  assign tick       = busy && (({1'b0, div_cnt} + 9'd1) >= {1'b0, divisor});
  assign accum_next = accum + cur_rate;

  // Handshake, divider and run state
  always_ff @(posedge CLK) begin
    if (reset) begin
      busy    <= 1'b0;
      pop_ack <= 1'b0;
      step    <= 1'b0;
      div_cnt <= '0;
      dir     <= 1'b0;
    end else begin
      step <= 1'b0;
      if (pop_ack && !pop_req) begin
        pop_ack <= 1'b0;
      end
      if (load) begin
        pop_ack <= 1'b1;
        dir     <= pop_move.dir;
        div_cnt <= '0;
        // Zero length move completes on load
        busy    <= pop_move.duration != '0;
      end else if (tick) begin
        div_cnt <= '0;
        step    <= accum_next > 64'sd0;
        if (remaining == 64'd1) begin
          busy <= 1'b0;
        end
      end else if (busy) begin
        div_cnt <= div_cnt + 8'd1;
      end
    end
  end

  // DDA datapath
  always_ff @(posedge CLK) begin
    if (load) begin
      remaining  <= pop_move.duration;
      cur_rate   <= pop_move.rate;
      rate_delta <= pop_move.rate_delta;
      accum      <= '0;
    end else if (tick) begin
      remaining <= remaining - 64'd1;
      // Rate for tick k+1
      cur_rate  <= cur_rate + rate_delta;
      if (accum_next > 64'sd0) begin
        accum <= accum_next - STEP_THRESHOLD;
      end else begin
        accum <= accum_next;
      end
    end
  end

endmodule

// File: verilog/move_queue.sv
module move_queue (
  input  logic              CLK,
  input  logic              reset,
  input  logic              push_req,
  output logic              push_ack,
  input  motion_pkg::move_t push_move,
  output logic              pop_req,
  input  logic              pop_ack,
  output motion_pkg::move_t pop_move
);
  import motion_pkg::*;

  move_t mem [MOVE_QUEUE_DEPTH];
  logic [MOVE_PTR_BITS-1:0] wr_ptr;
  logic [MOVE_PTR_BITS-1:0] rd_ptr;
  logic [MOVE_PTR_BITS:0]   count;
  logic full;
  logic empty;
  logic do_push;
  logic do_pop;

  assign full    = count == (MOVE_PTR_BITS + 1)'(MOVE_QUEUE_DEPTH);
  assign empty   = count == '0;
  // One entry per request, ack high blocks a second write
  assign do_push = push_req && !push_ack && !full;
  assign do_pop  = pop_req && pop_ack;

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      push_ack <= 1'b0;
      pop_req  <= 1'b0;
    end else begin
      // Push side four-phase
      if (do_push) begin
        wr_ptr   <= wr_ptr + 1'b1;
        push_ack <= 1'b1;
      end else if (!push_req) begin
        push_ack <= 1'b0;
      end
      // Pop side, wait for ack low before offering the next entry
      if (do_pop) begin
        rd_ptr  <= rd_ptr + 1'b1;
        pop_req <= 1'b0;
      end else if (!pop_req && !pop_ack && !empty) begin
        pop_req <= 1'b1;
      end
      count <= count + (MOVE_PTR_BITS + 1)'(do_push) - (MOVE_PTR_BITS + 1)'(do_pop);
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_move;
    end
  end

  // Head entry stays put until popped
  assign pop_move = mem[rd_ptr];

endmodule

// File: verilog/command_decoder.sv
module command_decoder (
  input  logic                  CLK,
  input  logic                  reset,
  input  motion_pkg::spi_word_u rx_word,
  input  logic                  word_done,
  output motion_pkg::spi_word_u tx_word,
  output logic                  push_req,
  input  logic                  push_ack,
  output motion_pkg::move_t     push_move,
  output logic                  enable,
  output logic [1:0]            microsteps,
  output logic [7:0]            divisor,
  input  logic signed [63:0]    enc_count
);
  import motion_pkg::*;

  logic       in_message;
  logic [7:0] msg_cmd;
  logic [1:0] data_cnt;
  move_t      move_build;
  logic       push_idle;
  logic       version_hdr;

  // No handshake in flight, both phases returned low
  assign push_idle   = !push_req && !push_ack;
  assign version_hdr = !in_message && (rx_word.hdr.cmd == CMD_VERSION);

  // Message FSM and settings registers
  always_ff @(posedge CLK) begin
    if (reset) begin
      in_message <= 1'b0;
      msg_cmd    <= '0;
      data_cnt   <= '0;
      enable     <= 1'b0;
      microsteps <= 2'd1;
      divisor    <= DIVISOR_RESET;
      push_req   <= 1'b0;
    end else begin
      // Queue took the move
      if (push_req && push_ack) begin
        push_req <= 1'b0;
      end
      if (word_done) begin
        if (!in_message) begin
          msg_cmd  <= rx_word.hdr.cmd;
          data_cnt <= '0;
          case (rx_word.hdr.cmd)
            CMD_MOVE:       in_message <= 1'b1;
            // Version reply goes out on the next word, swallow it
            CMD_VERSION:    in_message <= 1'b1;
            CMD_ENABLE:     enable <= rx_word.hdr.arg[0];
            CMD_DIVISOR:    divisor <= rx_word.hdr.arg[7:0];
            CMD_MICROSTEPS: microsteps <= rx_word.hdr.arg[1:0];
            default:        in_message <= 1'b0;
          endcase
        end else if (msg_cmd == CMD_MOVE && data_cnt != 2'd2) begin
          data_cnt <= data_cnt + 2'd1;
        end else begin
          in_message <= 1'b0;
          // Move dropped if the previous push is still pending
          if (msg_cmd == CMD_MOVE && push_idle) begin
            push_req <= 1'b1;
          end
        end
      end
    end
  end

  // Move assembly and reply word
  always_ff @(posedge CLK) begin
    if (word_done) begin
      if (!in_message) begin
        if (rx_word.hdr.cmd == CMD_MOVE) begin
          move_build.dir <= rx_word.hdr.arg[0];
        end
      end else if (msg_cmd == CMD_MOVE) begin
        case (data_cnt)
          2'd0: move_build.duration <= rx_word.data;
          2'd1: move_build.rate <= rx_word.data;
          default: begin
            // Held stable for the whole handshake
            if (push_idle) begin
              push_move <= '{dir:        move_build.dir,
                             duration:   move_build.duration,
                             rate:       move_build.rate,
                             rate_delta: rx_word.data};
            end
          end
        endcase
      end
      if (version_hdr) begin
        tx_word.data <= {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
      end else begin
        tx_word.data <= enc_count;
      end
    end
  end

endmodule

// File: verilog/spi_word_port.sv
module spi_word_port (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  sck,
  input  logic                  cs,
  input  logic                  copi,
  output logic                  cipo,
  input  motion_pkg::spi_word_u tx_word,
  output motion_pkg::spi_word_u rx_word,
  output logic                  word_done
);
  import motion_pkg::*;

  // Two sync flops, third stage only for edge detect
  logic [2:0] sck_s;
  logic [2:0] cs_s;
  logic [1:0] copi_s;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_active;
  logic [$clog2(WORD_BITS)-1:0] bit_cnt;
  logic [WORD_BITS-1:0]         rx_shift;
  logic [WORD_BITS-1:0]         tx_shift;

  assign sck_rise  = sck_s[1] & ~sck_s[2];
  assign sck_fall  = ~sck_s[1] & sck_s[2];
  assign cs_fall   = ~cs_s[1] & cs_s[2];
  assign cs_active = ~cs_s[1];

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_s  <= '0;
      cs_s   <= '1;
      copi_s <= '0;
    end else begin
      sck_s  <= {sck_s[1:0], sck};
      cs_s   <= {cs_s[1:0], cs};
      copi_s <= {copi_s[0], copi};
    end
  end

  // Bit counter, cleared while deselected
  always_ff @(posedge CLK) begin
    if (reset) begin
      bit_cnt   <= '0;
      word_done <= 1'b0;
    end else begin
      word_done <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        // Last bit of the word taken, counter wraps to 0
        if (&bit_cnt) begin
          word_done <= 1'b1;
        end
      end
    end
  end

  // MSB first both ways
  always_ff @(posedge CLK) begin
    if (sck_rise && cs_active) begin
      rx_shift <= {rx_shift[WORD_BITS-2:0], copi_s[1]};
    end
    if (cs_fall) begin
      tx_shift <= tx_word;
    end else if (sck_fall && cs_active) begin
      tx_shift <= {tx_shift[WORD_BITS-2:0], 1'b0};
    end
  end

  assign rx_word = rx_shift;
  assign cipo    = tx_shift[WORD_BITS-1];

endmodule

// File: verilog/motion_pkg.sv
package motion_pkg;

  // Command codes carried in the top byte of a header word
  localparam logic [7:0] CMD_MOVE       = 8'd1;
  localparam logic [7:0] CMD_ENABLE     = 8'd2;
  localparam logic [7:0] CMD_DIVISOR    = 8'd3;
  localparam logic [7:0] CMD_MICROSTEPS = 8'd4;
  localparam logic [7:0] CMD_VERSION    = 8'd5;

  // API version returned after a version header
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

  localparam int WORD_BITS        = 64;
  localparam int MOVE_QUEUE_DEPTH = 4;
  localparam int MOVE_PTR_BITS    = $clog2(MOVE_QUEUE_DEPTH);

  // One full step worth of accumulated rate, 2**40
  localparam logic signed [63:0] STEP_THRESHOLD = 64'sh0000_0100_0000_0000;

  // Ticks of CLK per DDA tick after reset
  localparam logic [7:0] DIVISOR_RESET = 8'd40;

  // One coordinated move as queued and executed
  typedef struct packed {
    logic               dir;
    logic        [63:0] duration;
    logic signed [63:0] rate;
    logic signed [63:0] rate_delta;
  } move_t;

  // Header layout, command byte then argument
  typedef struct packed {
    logic [7:0]  cmd;
    logic [55:0] arg;
  } spi_header_t;

  // Same SPI word, either a header or a signed data value
  typedef union packed {
    spi_header_t        hdr;
    logic signed [63:0] data;
  } spi_word_u;

endpackage
